/* fe_pkg.sv */
// fetch front end definitions
`default_nettype none

package fe_pkg;

  // fetch address and block geometry
  localparam int unsigned addr_w = 16;
  typedef logic [addr_w-1:0] addr_t;

  localparam int unsigned block_bytes = 16;
  localparam int unsigned line_lsb = $clog2(block_bytes);  // 4, low bits always zero

  // target buffer, line from bits 7:4, tag from bits 15:8
  localparam int unsigned tb_lines = 16;
  localparam int unsigned line_w = $clog2(tb_lines);
  localparam int unsigned tag_w = 8;
  localparam int unsigned tag_lsb = addr_w - tag_w;
  typedef logic [line_w-1:0] line_t;
  typedef logic [tag_w-1:0] tag_t;

  localparam int unsigned hist_w = 8;
  typedef logic [hist_w-1:0] hist_t;

  // direction tables, two bits per entry (one per slot)
  localparam int unsigned pred_depth = 256;
  localparam int unsigned pidx_w = $clog2(pred_depth);
  typedef logic [pidx_w-1:0] pidx_t;

  localparam int unsigned n_tables = 3;
  localparam int unsigned idx_hist_bits [n_tables] = '{2, 4, 6};  // tables a, b, c

  localparam int unsigned stack_depth = 8;
  localparam int unsigned sp_w = $clog2(stack_depth);

  typedef enum logic [1:0] {
    kind_cond,
    kind_jump,
    kind_call,
    kind_ret
  } br_kind_t;

  // block address bits above the low history bits
  function automatic pidx_t pred_idx(input addr_t ip, input hist_t h,
                                     input int unsigned hist_bits);
    addr_t blk;
    hist_t low;
    blk = ip >> line_lsb;
    low = h & hist_t'((1 << hist_bits) - 1);
    return pidx_t'(blk << hist_bits) | pidx_t'(low);
  endfunction

endpackage

`default_nettype wire

/* fetch_trace.txt */
// valid_slot_srcip_target_kind_hist_mispred_nextip_expfetchip_exphist, one record per cycle
// kind 0 cond, 1 jump, 2 call, 3 ret
1_0_0150_0300_1_00_0_0000_0100_00 // install jump at 0150
1_0_0330_0500_0_00_0_0000_0110_00 // install cond at 0330
1_0_0520_0860_1_00_0_0000_0120_00 // slot 0 jump at 0520
1_1_0520_0900_1_00_0_0000_0130_00 // slot 1 jump at 0520
1_0_0860_0a00_2_00_0_0000_0140_00 // call at 0860
1_0_0a10_0000_3_00_0_0000_0150_00 // ret at 0a10
0_0_0000_0000_0_00_0_0000_0300_01 // jump taken
0_0_0000_0000_0_00_0_0000_0310_01
0_0_0000_0000_0_00_0_0000_0320_01
0_0_0000_0000_0_00_0_0000_0330_01
1_0_0330_0500_0_01_1_0500_0340_02 // cond fell through, now mispredict
0_0_0000_0000_0_00_0_0000_0350_02
1_1_0750_0330_1_01_1_0330_0500_01 // redirected, then send fetch back to 0330
0_0_0000_0000_0_00_0_0000_0510_01
0_0_0000_0000_0_00_0_0000_0330_01 // same history, cond now taken
0_0_0000_0000_0_00_0_0000_0500_03
0_0_0000_0000_0_00_0_0000_0510_03
0_0_0000_0000_0_00_0_0000_0520_03 // both slots hit
0_0_0000_0000_0_00_0_0000_0860_07 // slot 0 target, call
0_0_0000_0000_0_00_0_0000_0a00_0f
0_0_0000_0000_0_00_0_0000_0a10_0f // ret
0_0_0000_0000_0_00_0_0000_0870_1f // call address plus 16
0_0_0000_0000_0_00_0_0000_0880_1f

/* frontend_chk.sv */
// fetch select checker
`timescale 1ns/1ns
`default_nettype none

module frontend_chk #(
  parameter fe_pkg::addr_t INIT_IP = 16'h0100
) (
  input wire                clk,
  input wire                rst,
  input wire fe_pkg::addr_t fetch_ip,
  input wire                push,
  input wire                pop
);
  import fe_pkg::*;

  int unsigned fail_count = 0;  // sticky failure count

  block_aligned: assert property (@(posedge clk) disable iff (rst)
      fetch_ip[line_lsb-1:0] == '0)
    else begin
      $error("fetch_ip %h is not block aligned", fetch_ip);
      fail_count++;
    end

  // stack moves one way per cycle
  push_pop_excl: assert property (@(posedge clk) disable iff (rst)
      !(push && pop))
    else begin
      $error("push and pop high together");
      fail_count++;
    end

  reset_ip: assert property (@(posedge clk) rst |=> (fetch_ip == INIT_IP))
    else begin
      $error("fetch_ip %h after reset, expected %h", fetch_ip, INIT_IP);
      fail_count++;
    end

endmodule

bind next_ip_select frontend_chk #(.INIT_IP(INIT_IP)) chk (
  .clk(clk), .rst(rst), .fetch_ip(fetch_ip), .push(push), .pop(pop)
);

`default_nettype wire

/* frontend_top.sv */
// instruction fetch front end
`timescale 1ns/1ns
`default_nettype none

module frontend_top #(
  parameter fe_pkg::addr_t INIT_IP = 16'h0100
) (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     upd_valid,
  input  wire                     upd_slot,
  input  wire fe_pkg::addr_t      upd_src_ip,
  input  wire fe_pkg::addr_t      upd_target,
  input  wire fe_pkg::br_kind_t   upd_kind,
  input  wire fe_pkg::hist_t      upd_hist,
  input  wire                     upd_mispred,
  input  wire fe_pkg::addr_t      upd_next_ip,
  output fe_pkg::addr_t           fetch_ip,
  output fe_pkg::hist_t           hist
);
  import fe_pkg::*;

  logic     wr_en;
  logic     wr_slot;
  line_t    wr_line;
  tag_t     wr_tag;
  addr_t    wr_target;
  br_kind_t wr_kind;
  logic     flip_en;
  logic     flip_slot;
  pidx_t    flip_idx_a;
  pidx_t    flip_idx_b;
  pidx_t    flip_idx_c;
  logic     redirect_en;
  addr_t    redirect_ip;
  hist_t    redirect_hist;

  logic     hit0;
  logic     hit1;
  br_kind_t kind0;
  br_kind_t kind1;
  addr_t    target0;
  addr_t    target1;
  logic     pred_taken0;
  logic     pred_taken1;

  logic     push;
  logic     pop;
  addr_t    push_ip;
  addr_t    top_ip;

  update_capture u_capture (
    .clk(clk), .rst(rst),
    .upd_valid(upd_valid), .upd_slot(upd_slot), .upd_src_ip(upd_src_ip),
    .upd_target(upd_target), .upd_kind(upd_kind), .upd_hist(upd_hist),
    .upd_mispred(upd_mispred), .upd_next_ip(upd_next_ip),
    .wr_en(wr_en), .wr_slot(wr_slot), .wr_line(wr_line), .wr_tag(wr_tag),
    .wr_target(wr_target), .wr_kind(wr_kind),
    .flip_en(flip_en), .flip_slot(flip_slot),
    .flip_idx_a(flip_idx_a), .flip_idx_b(flip_idx_b), .flip_idx_c(flip_idx_c),
    .redirect_en(redirect_en), .redirect_ip(redirect_ip), .redirect_hist(redirect_hist)
  );

  target_buffer u_btb (
    .clk(clk), .rst(rst), .fetch_ip(fetch_ip),
    .wr_en(wr_en), .wr_slot(wr_slot), .wr_line(wr_line), .wr_tag(wr_tag),
    .wr_target(wr_target), .wr_kind(wr_kind),
    .hit0(hit0), .hit1(hit1), .kind0(kind0), .kind1(kind1),
    .target0(target0), .target1(target1)
  );

  xor_predictor u_pred (
    .clk(clk), .rst(rst), .fetch_ip(fetch_ip), .hist(hist),
    .flip_en(flip_en), .flip_slot(flip_slot),
    .flip_idx_a(flip_idx_a), .flip_idx_b(flip_idx_b), .flip_idx_c(flip_idx_c),
    .pred_taken0(pred_taken0), .pred_taken1(pred_taken1)
  );

  return_stack u_ras (
    .clk(clk), .rst(rst), .push(push), .push_ip(push_ip), .pop(pop), .top_ip(top_ip)
  );

  next_ip_select #(.INIT_IP(INIT_IP)) u_sel (
    .clk(clk), .rst(rst),
    .hit0(hit0), .hit1(hit1), .kind0(kind0), .kind1(kind1),
    .target0(target0), .target1(target1),
    .pred_taken0(pred_taken0), .pred_taken1(pred_taken1), .top_ip(top_ip),
    .redirect_en(redirect_en), .redirect_ip(redirect_ip), .redirect_hist(redirect_hist),
    .fetch_ip(fetch_ip), .hist(hist), .push(push), .push_ip(push_ip), .pop(pop)
  );

endmodule

`default_nettype wire

/* next_ip_select.sv */
// next fetch address select
`timescale 1ns/1ns
`default_nettype none

module next_ip_select #(
  parameter fe_pkg::addr_t INIT_IP = 16'h0100
) (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     hit0,
  input  wire                     hit1,
  input  wire fe_pkg::br_kind_t   kind0,
  input  wire fe_pkg::br_kind_t   kind1,
  input  wire fe_pkg::addr_t      target0,
  input  wire fe_pkg::addr_t      target1,
  input  wire                     pred_taken0,
  input  wire                     pred_taken1,
  input  wire fe_pkg::addr_t      top_ip,
  input  wire                     redirect_en,
  input  wire fe_pkg::addr_t      redirect_ip,
  input  wire fe_pkg::hist_t      redirect_hist,
  output fe_pkg::addr_t           fetch_ip,
  output fe_pkg::hist_t           hist,
  output logic                    push,
  output fe_pkg::addr_t           push_ip,
  output logic                    pop
);
  import fe_pkg::*;

  logic     take0;
  logic     take1;
  logic     any_taken;
  br_kind_t sel_kind;
  addr_t    sel_target;
  addr_t    fall_ip;
  addr_t    next_ip;
  hist_t    next_hist;

  // unconditional kinds always go
  assign take0 = hit0 && (kind0 != kind_cond || pred_taken0);
  assign take1 = hit1 && (kind1 != kind_cond || pred_taken1);
  assign any_taken = take0 || take1;

  assign sel_kind   = take0 ? kind0 : kind1;  // slot 0 wins
  assign sel_target = take0 ? target0 : target1;
  assign fall_ip    = fetch_ip + addr_t'(block_bytes);

  always_comb begin
    if (any_taken) begin
      next_hist = {hist[hist_w-2:0], 1'b1};
      next_ip   = (sel_kind == kind_ret) ? top_ip : sel_target;
    end else if (hit0 || hit1) begin
      next_hist = {hist[hist_w-2:0], 1'b0};
      next_ip   = fall_ip;
    end else begin
      next_hist = hist;
      next_ip   = fall_ip;
    end
  end

  // stack moves only when the prediction is used
  assign push    = !redirect_en && any_taken && (sel_kind == kind_call);
  assign pop     = !redirect_en && any_taken && (sel_kind == kind_ret);
  assign push_ip = fall_ip;

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_ip <= INIT_IP;
      hist     <= '0;
    end else if (redirect_en) begin
      fetch_ip <= redirect_ip;
      hist     <= redirect_hist;
    end else begin
      fetch_ip <= next_ip;
      hist     <= next_hist;
    end
  end

endmodule

`default_nettype wire

/* return_stack.sv */
// return address stack
`timescale 1ns/1ns
`default_nettype none

module return_stack (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  push,
  input  wire fe_pkg::addr_t   push_ip,
  input  wire                  pop,
  output fe_pkg::addr_t        top_ip
);
  import fe_pkg::*;

  addr_t           stk [stack_depth];
  logic [sp_w-1:0] sp;

  assign top_ip = stk[sp];

  always_ff @(posedge clk) begin
    if (rst) begin
      sp <= '0;
    end else if (push) begin
      sp <= sp + 1'b1;  // wraps on overflow
    end else if (pop) begin
      sp <= sp - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      stk[sp_w'(sp + 1'b1)] <= push_ip;
    end
  end

endmodule

`default_nettype wire

/* sim.f */
fe_pkg.sv
update_capture.sv
target_buffer.sv
xor_predictor.sv
return_stack.sv
next_ip_select.sv
frontend_top.sv
frontend_chk.sv
tb_frontend.sv

/* target_buffer.sv */
// branch target buffer
`timescale 1ns/1ns
`default_nettype none

module target_buffer (
  input  wire                     clk,
  input  wire                     rst,
  input  wire fe_pkg::addr_t      fetch_ip,
  input  wire                     wr_en,
  input  wire                     wr_slot,
  input  wire fe_pkg::line_t      wr_line,
  input  wire fe_pkg::tag_t       wr_tag,
  input  wire fe_pkg::addr_t      wr_target,
  input  wire fe_pkg::br_kind_t   wr_kind,
  output logic                    hit0,
  output logic                    hit1,
  output fe_pkg::br_kind_t        kind0,
  output fe_pkg::br_kind_t        kind1,
  output fe_pkg::addr_t           target0,
  output fe_pkg::addr_t           target1
);
  import fe_pkg::*;

  logic [tb_lines-1:0][1:0] valid;
  tag_t     tag_mem    [tb_lines][2];
  br_kind_t kind_mem   [tb_lines][2];
  addr_t    target_mem [tb_lines][2];

  line_t rd_line;
  tag_t  rd_tag;

  assign rd_line = fetch_ip[tag_lsb-1:line_lsb];
  assign rd_tag  = fetch_ip[addr_w-1:tag_lsb];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else if (wr_en) begin
      valid[wr_line][wr_slot] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag_mem[wr_line][wr_slot]    <= wr_tag;
      kind_mem[wr_line][wr_slot]   <= wr_kind;
      target_mem[wr_line][wr_slot] <= wr_target;
    end
  end

  // both slots of the line checked in parallel
  assign hit0 = valid[rd_line][0] && (tag_mem[rd_line][0] == rd_tag);
  assign hit1 = valid[rd_line][1] && (tag_mem[rd_line][1] == rd_tag);

  assign kind0   = kind_mem[rd_line][0];
  assign kind1   = kind_mem[rd_line][1];
  assign target0 = target_mem[rd_line][0];
  assign target1 = target_mem[rd_line][1];

endmodule

`default_nettype wire

/* tb_frontend.sv */
// fetch front end testbench
`timescale 1ns/1ns
`default_nettype none

module tb_frontend;
  import fe_pkg::*;

  localparam int    n_recs     = 23;
  localparam int    clk_per    = 100;
  localparam int    rst_cycles = 5;
  localparam addr_t init_ip    = 16'h0100;

  logic     clk;
  logic     rst;
  logic     upd_valid;
  logic     upd_slot;
  addr_t    upd_src_ip;
  addr_t    upd_target;
  br_kind_t upd_kind;
  hist_t    upd_hist;
  logic     upd_mispred;
  addr_t    upd_next_ip;
  addr_t    fetch_ip;
  hist_t    hist;

  // one 24 digit hex word per cycle, field layout as in the trace header
  logic [95:0] trace_mem [n_recs];

  frontend_top #(.INIT_IP(init_ip)) uut (
    .clk(clk), .rst(rst),
    .upd_valid(upd_valid), .upd_slot(upd_slot), .upd_src_ip(upd_src_ip),
    .upd_target(upd_target), .upd_kind(upd_kind), .upd_hist(upd_hist),
    .upd_mispred(upd_mispred), .upd_next_ip(upd_next_ip),
    .fetch_ip(fetch_ip), .hist(hist)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_per / 2) clk = ~clk;
  end

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic drive_update(input logic [95:0] rec);
    upd_valid   <= rec[92];
    upd_slot    <= rec[88];
    upd_src_ip  <= rec[87:72];
    upd_target  <= rec[71:56];
    upd_kind    <= br_kind_t'(rec[53:52]);
    upd_hist    <= rec[51:44];
    upd_mispred <= rec[40];
    upd_next_ip <= rec[39:24];
  endtask

  task automatic check_fetch(input int idx, input logic [95:0] rec);
    addr_t want_ip;
    hist_t want_hist;
    want_ip   = rec[23:8];
    want_hist = rec[7:0];
    assert (fetch_ip === want_ip)
      else stop_with_failure($sformatf("Mismatch at %0t ns: record %0d fetch_ip %h, expected %h",
                                       $time, idx, fetch_ip, want_ip));
    assert (hist === want_hist)
      else stop_with_failure($sformatf("Mismatch at %0t ns: record %0d hist %h, expected %h",
                                       $time, idx, hist, want_hist));
    assert (uut.u_sel.chk.fail_count == 0)
      else stop_with_failure("a bound assertion on next_ip_select has failed");
  endtask

  initial begin
    rst         = 1'b1;
    upd_valid   = 1'b0;
    upd_slot    = 1'b0;
    upd_src_ip  = '0;
    upd_target  = '0;
    upd_kind    = kind_cond;
    upd_hist    = '0;
    upd_mispred = 1'b0;
    upd_next_ip = '0;
    $readmemh("fetch_trace.txt", trace_mem);
    assert (!$isunknown(trace_mem[n_recs-1]))
      else stop_with_failure("trace file fetch_trace.txt is missing or too short");

    repeat (rst_cycles) @(posedge clk);
    rst <= 1'b0;

    // record i drives its update and expects the fetch state after this edge
    for (int i = 0; i < n_recs; i++) begin
      drive_update(trace_mem[i]);
      @(negedge clk);
      check_fetch(i, trace_mem[i]);
      @(posedge clk);
    end

    if (uut.u_sel.chk.fail_count == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      stop_with_failure("a bound assertion on next_ip_select has failed");
    end
  end

  // reset plus trace length plus margin
  initial begin
    #((rst_cycles + n_recs + 20) * clk_per);
    stop_with_failure("timeout: the trace did not finish in the expected number of cycles");
  end

endmodule

`default_nettype wire

/* update_capture.sv */
// retire update capture
`timescale 1ns/1ns
`default_nettype none

module update_capture (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     upd_valid,
  input  wire                     upd_slot,
  input  wire fe_pkg::addr_t      upd_src_ip,
  input  wire fe_pkg::addr_t      upd_target,
  input  wire fe_pkg::br_kind_t   upd_kind,
  input  wire fe_pkg::hist_t      upd_hist,
  input  wire                     upd_mispred,
  input  wire fe_pkg::addr_t      upd_next_ip,
  output logic                    wr_en,
  output logic                    wr_slot,
  output fe_pkg::line_t           wr_line,
  output fe_pkg::tag_t            wr_tag,
  output fe_pkg::addr_t           wr_target,
  output fe_pkg::br_kind_t        wr_kind,
  output logic                    flip_en,
  output logic                    flip_slot,
  output fe_pkg::pidx_t           flip_idx_a,
  output fe_pkg::pidx_t           flip_idx_b,
  output fe_pkg::pidx_t           flip_idx_c,
  output logic                    redirect_en,
  output fe_pkg::addr_t           redirect_ip,
  output fe_pkg::hist_t           redirect_hist
);
  import fe_pkg::*;

  addr_t src_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_en       <= 1'b0;
      flip_en     <= 1'b0;
      redirect_en <= 1'b0;
    end else begin
      wr_en       <= upd_valid;                // every update rewrites its slot
      flip_en     <= upd_valid && upd_mispred;
      redirect_en <= upd_valid && upd_mispred;
    end
  end

  always_ff @(posedge clk) begin
    if (upd_valid) begin
      src_q         <= upd_src_ip;
      wr_slot       <= upd_slot;
      wr_target     <= upd_target;
      wr_kind       <= upd_kind;
      redirect_ip   <= upd_next_ip;
      redirect_hist <= upd_hist;  // history seen at the branch lookup
    end
  end

  assign wr_line   = src_q[tag_lsb-1:line_lsb];
  assign wr_tag    = src_q[addr_w-1:tag_lsb];
  assign flip_slot = wr_slot;

  // same indexing as the lookup side
  assign flip_idx_a = pred_idx(src_q, redirect_hist, idx_hist_bits[0]);
  assign flip_idx_b = pred_idx(src_q, redirect_hist, idx_hist_bits[1]);
  assign flip_idx_c = pred_idx(src_q, redirect_hist, idx_hist_bits[2]);

endmodule

`default_nettype wire

/* xor_predictor.sv */
// three table xor direction predictor
`timescale 1ns/1ns
`default_nettype none

module xor_predictor (
  input  wire                  clk,
  input  wire                  rst,
  input  wire fe_pkg::addr_t   fetch_ip,
  input  wire fe_pkg::hist_t   hist,
  input  wire                  flip_en,
  input  wire                  flip_slot,
  input  wire fe_pkg::pidx_t   flip_idx_a,
  input  wire fe_pkg::pidx_t   flip_idx_b,
  input  wire fe_pkg::pidx_t   flip_idx_c,
  output logic                 pred_taken0,
  output logic                 pred_taken1
);
  import fe_pkg::*;

  logic [n_tables-1:0][pred_depth-1:0][1:0] tbl;

  pidx_t rd_idx [n_tables];
  pidx_t wr_idx [n_tables];
  logic [n_tables-1:0] bit0;
  logic [n_tables-1:0] bit1;

  assign wr_idx[0] = flip_idx_a;
  assign wr_idx[1] = flip_idx_b;
  assign wr_idx[2] = flip_idx_c;

  for (genvar t = 0; t < n_tables; t++) begin : g_rd
    // longer history, fewer address bits
    assign rd_idx[t] = pred_idx(fetch_ip, hist, idx_hist_bits[t]);
    assign bit0[t]   = tbl[t][rd_idx[t]][0];
    assign bit1[t]   = tbl[t][rd_idx[t]][1];
  end

  assign pred_taken0 = ^bit0;
  assign pred_taken1 = ^bit1;

  always_ff @(posedge clk) begin
    if (rst) begin
      tbl <= '0;
    end else if (flip_en) begin
      for (int t = 0; t < n_tables; t++) begin
        tbl[t][wr_idx[t]][flip_slot] <= ~tbl[t][wr_idx[t]][flip_slot];  // inverts the xor
      end
    end
  end

endmodule

`default_nettype wire
